/* all.f */
source/rv_pkg.sv
source/pipe_ctrl_if.sv
source/pipe_reg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/hazard_ctrl.sv
source/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu_top.sv

/* testbench/cpu_stim.txt */
// @00 program words by word address (byte address / 4)
// @40 commit count, then records: pc rd wen data (rd and data ignored when wen is 0)
@00
00500093    // 00 addi x1, x0, 5
00308113    // 04 addi x2, x1, 3
002081b3    // 08 add  x3, x1, x2
40310233    // 0c sub  x4, x2, x3
001222b3    // 10 slt  x5, x4, x1
00a1a313    // 14 slti x6, x3, 10
0041c3b3    // 18 xor  x7, x3, x4
0033f433    // 1c and  x8, x7, x3
03046493    // 20 ori  x9, x8, 0x30
12345537    // 24 lui  x10, 0x12345
fff54593    // 28 xori x11, x10, -1
7ff5f613    // 2c andi x12, x11, 0x7ff
00708013    // 30 addi x0, x1, 7
001006b3    // 34 add  x13, x0, x1
00628463    // 38 beq  x5, x6, +8 not taken
00d08463    // 3c beq  x1, x13, +8 taken
06300713    // 40 addi x14, x0, 99 never commits
00300793    // 44 addi x15, x0, 3
00280813    // 48 addi x16, x16, 2
fff78793    // 4c addi x15, x15, -1
fe079ce3    // 50 bne  x15, x0, -8
008008ef    // 54 jal  x17, +8
00100913    // 58 addi x18, x0, 1 never commits
40f80a33    // 5c sub  x20, x16, x15
0000006f    // 60 jal  x0, 0
@40
0000001e    // commit count
00000000 01 1 00000005   00000004 02 1 00000008
00000008 03 1 0000000d   0000000c 04 1 fffffffb
00000010 05 1 00000001   00000014 06 1 00000000
00000018 07 1 fffffff6   0000001c 08 1 00000004
00000020 09 1 00000034   00000024 0a 1 12345000
00000028 0b 1 edcbafff   0000002c 0c 1 000007ff
00000030 00 0 00000000   00000034 0d 1 00000005
00000038 00 0 00000000   0000003c 00 0 00000000
00000044 0f 1 00000003   00000048 10 1 00000002    // loop pass 1
0000004c 0f 1 00000002   00000050 00 0 00000000
00000048 10 1 00000004   0000004c 0f 1 00000001    // loop pass 2
00000050 00 0 00000000   00000048 10 1 00000006
0000004c 0f 1 00000000   00000050 00 0 00000000    // bne falls through
00000054 11 1 00000058   0000005c 14 1 00000006
00000060 00 0 00000000   00000060 00 0 00000000

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;
    import rv_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int HALF_PERIOD  = CLK_PERIOD / 2;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;                        // after the rising edge
    localparam int STIM_WORDS   = 256;
    localparam int IMEM_WORDS   = 64;                       // program image at word 0
    localparam int EXP_BASE     = 'h40;                     // commit count, then records
    localparam int REC_WORDS    = 4;
    localparam int MAX_DELAY    = 5;

    logic                  clock;
    logic                  rst_n;
    logic                  instr_req;
    logic [XLEN-1:0]       instr_addr;
    logic [XLEN-1:0]       instr_rdata;
    logic                  instr_ack;
    logic                  commit_valid;
    logic [XLEN-1:0]       commit_pc;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic                  commit_wen;
    logic [XLEN-1:0]       commit_data;

    logic [31:0] stim_mem [STIM_WORDS];
    integer      seed        = 32'h38e6e231;
    int          num_commits = 0;
    int          commit_idx  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          check_count = 0;
    int          error_count = 0;

    cpu_top #(.RESET_PC(32'h0000_0000)) i_cpu_top (
        .clock        (clock       ),
        .rst_n        (rst_n       ),
        .instr_req    (instr_req   ),
        .instr_addr   (instr_addr  ),
        .instr_rdata  (instr_rdata ),
        .instr_ack    (instr_ack   ),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc   ),
        .commit_rd    (commit_rd   ),
        .commit_wen   (commit_wen  ),
        .commit_data  (commit_data )
    );

    always #(HALF_PERIOD) clock = ~clock;

    // -------------------------------------------------------------------------
    // helpers
    // -------------------------------------------------------------------------
    task automatic load_stimulus();
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim_mem[i] = 32'hbad0_0000 ^ 32'(i);           // unused words
        end
        $readmemh("testbench/cpu_stim.txt", stim_mem);
        num_commits = int'(stim_mem[EXP_BASE]);
        if (num_commits < 1 || EXP_BASE + 1 + REC_WORDS * num_commits > STIM_WORDS) begin
            $display("stimulus file gives an invalid commit count of %0d", num_commits);
            error_count++;
            num_commits = 0;
        end
        cycle_limit = 12 * num_commits + 100;
    endtask

    function automatic int next_delay();
        return $unsigned($random(seed)) % (MAX_DELAY + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_commit(input int idx);
        int base;
        base = EXP_BASE + 1 + REC_WORDS * idx;
        check_value($sformatf("commit %0d pc", idx), stim_mem[base], commit_pc);
        check_value($sformatf("commit %0d wen", idx), stim_mem[base + 2], 32'(commit_wen));
        if (stim_mem[base + 2] != 32'd0) begin              // rd and data only on writes
            check_value($sformatf("commit %0d rd", idx), stim_mem[base + 1], 32'(commit_rd));
            check_value($sformatf("commit %0d data", idx), stim_mem[base + 3], commit_data);
        end
    endtask

    // one four-phase transfer, req already seen high
    task automatic serve_fetch();
        int delay;
        delay = next_delay();
        repeat (delay) begin
            @(posedge clock);
            #(DRIVE_DELAY);
        end
        if (instr_addr[1:0] != 2'b00 || instr_addr >= 32'(IMEM_WORDS * 4)) begin
            $display("fetch from address %h is outside the program image", instr_addr);
            error_count++;
            instr_rdata = 32'h0000_0013;                    // nop
        end else begin
            instr_rdata = stim_mem[instr_addr >> 2];
        end
        instr_ack = 1'b1;
        do begin
            @(posedge clock);
            #(DRIVE_DELAY);
        end while (instr_req);
        delay = next_delay();
        repeat (delay) begin
            @(posedge clock);
            #(DRIVE_DELAY);
        end
        instr_ack = 1'b0;
    endtask

    task automatic print_summary();
        $display("checks %0d, errors %0d, commits %0d of %0d, cycles %0d",
                 check_count, error_count, commit_idx, num_commits, cycle_count);
    endtask

    task automatic finish_run();
        print_summary();
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // -------------------------------------------------------------------------
    // processes
    // -------------------------------------------------------------------------
    initial begin
        clock       = 1'b0;
        rst_n       = 1'b1;
        instr_ack   = 1'b0;
        instr_rdata = '0;
        load_stimulus();
        #(DRIVE_DELAY);
        rst_n = 1'b0;                                       // clean falling edge
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
    end

    // instruction memory
    initial begin
        wait (rst_n === 1'b0);
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clock);
            #(DRIVE_DELAY);
            if (instr_req) begin
                serve_fetch();
            end
        end
    end

    initial begin
        wait (rst_n === 1'b0);
        wait (rst_n === 1'b1);
        while (commit_idx < num_commits) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            if (commit_valid) begin
                check_commit(commit_idx);
                commit_idx++;
            end
        end
        finish_run();
    end

    initial begin
        wait (rst_n === 1'b0);
        wait (rst_n === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, only %0d of %0d commits seen",
                 cycle_count, commit_idx, num_commits);
        print_summary();
        $display("Regression failed");
        $finish;
    end

endmodule

/* testbench/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
    input logic                          clock,
    input logic                          rst_n,
    input logic                          instr_req,
    input logic [rv_pkg::XLEN-1:0]       instr_addr,
    input logic                          instr_ack,
    input logic                          commit_valid,
    input logic [rv_pkg::REG_ADDR_W-1:0] commit_rd,
    input logic                          commit_wen
);

    // -------------------------------------------------------------------------
    // fetch handshake
    // -------------------------------------------------------------------------
    req_held: assert property (@(posedge clock) disable iff (!rst_n)
        instr_req && !instr_ack |=> instr_req && $stable(instr_addr))
        else $error("fetch request dropped or address moved before ack");

    req_ends: assert property (@(posedge clock) disable iff (!rst_n)
        instr_req && instr_ack |=> !instr_req)                 // ack seen, req drops
        else $error("fetch request still high after ack was seen");

    no_rise_under_ack: assert property (@(posedge clock) disable iff (!rst_n)
        !instr_req && instr_ack |=> !instr_req)
        else $error("fetch request raised while ack still high");

    first_req: assert property (@(posedge clock)
        $rose(rst_n) |=> instr_req)
        else $error("no fetch request on the first edge after reset");

    // -------------------------------------------------------------------------
    // commit port and reset
    // -------------------------------------------------------------------------
    wen_needs_rd: assert property (@(posedge clock) disable iff (!rst_n)
        commit_wen |-> (commit_rd != '0))
        else $error("commit write enable with rd zero");

    quiet_in_reset: assert property (@(posedge clock)
        !rst_n |-> !instr_req && !commit_valid)
        else $error("request or commit active during reset");

endmodule

bind cpu_top cpu_props i_cpu_props (
    .clock        (clock       ),
    .rst_n        (rst_n       ),
    .instr_req    (instr_req   ),
    .instr_addr   (instr_addr  ),
    .instr_ack    (instr_ack   ),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd   ),
    .commit_wen   (commit_wen  )
);

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
) (
    input  logic                          clock,
    input  logic                          rst_n,
    output logic                          instr_req,
    output logic [rv_pkg::XLEN-1:0]       instr_addr,
    input  logic [rv_pkg::XLEN-1:0]       instr_rdata,
    input  logic                          instr_ack,
    output logic                          commit_valid,
    output logic [rv_pkg::XLEN-1:0]       commit_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic                          commit_wen,
    output logic [rv_pkg::XLEN-1:0]       commit_data
);
    import rv_pkg::*;

    logic    if_valid;
    if_pkt_t if_data;
    logic    id_valid;
    if_pkt_t id_data;
    logic    dec_valid;
    ex_pkt_t dec_data;
    logic    ex_valid;
    ex_pkt_t ex_data;
    logic    exe_valid;
    wb_pkt_t exe_data;
    logic    wb_valid;
    wb_pkt_t wb_data;

    pipe_ctrl_if ctl ();

    // ---------------------------------------------------------------------
    // fetch and decode
    // ---------------------------------------------------------------------
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clock       (clock       ),
        .rst_n       (rst_n       ),
        .instr_req   (instr_req   ),
        .instr_addr  (instr_addr  ),
        .instr_rdata (instr_rdata ),
        .instr_ack   (instr_ack   ),
        .ctl         (ctl.stage   ),
        .if_valid    (if_valid    ),
        .if_data     (if_data     )
    );

    pipe_reg #(.payload_t(if_pkt_t)) u_id_reg (
        .clock     (clock       ),
        .rst_n     (rst_n       ),
        .load      (if_valid    ),
        .flush     (ctl.flush_d ),
        .in_valid  (if_valid    ),
        .in_data   (if_data     ),
        .out_valid (id_valid    ),
        .out_data  (id_data     )
    );

    decode_unit u_decode (
        .clock    (clock     ),
        .rst_n    (rst_n     ),
        .id_valid (id_valid  ),
        .id_data  (id_data   ),
        .wb_valid (wb_valid  ),
        .wb_data  (wb_data   ),
        .ex_valid (dec_valid ),
        .ex_data  (dec_data  )
    );

    // ---------------------------------------------------------------------
    // execute and writeback
    // ---------------------------------------------------------------------
    pipe_reg #(.payload_t(ex_pkt_t)) u_ex_reg (
        .clock     (clock       ),
        .rst_n     (rst_n       ),
        .load      (dec_valid   ),
        .flush     (ctl.flush_e ),
        .in_valid  (dec_valid   ),
        .in_data   (dec_data    ),
        .out_valid (ex_valid    ),
        .out_data  (ex_data     )
    );

    execute_unit u_execute (
        .ex_valid     (ex_valid  ),
        .ex_data      (ex_data   ),
        .wb_data      (wb_data   ),
        .ctl          (ctl.stage ),
        .wb_out_valid (exe_valid ),
        .wb_out       (exe_data  )
    );

    pipe_reg #(.payload_t(wb_pkt_t)) u_wb_reg (
        .clock     (clock     ),
        .rst_n     (rst_n     ),
        .load      (exe_valid ),
        .flush     (1'b0      ),                             // commits are never refused
        .in_valid  (exe_valid ),
        .in_data   (exe_data  ),
        .out_valid (wb_valid  ),
        .out_data  (wb_data   )
    );

    hazard_ctrl u_hazard_ctrl (
        .ctl (ctl.ctrl)
    );

    assign ctl.wb_rd  = wb_data.rd;
    assign ctl.wb_wen = wb_valid && wb_data.reg_wen;

    // commit port straight from the writeback register
    assign commit_valid = wb_valid;
    assign commit_pc    = wb_data.pc;
    assign commit_rd    = wb_data.rd;
    assign commit_wen   = wb_valid && wb_data.reg_wen;
    assign commit_data  = wb_data.result;

endmodule

/* source/hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl (
    pipe_ctrl_if.ctrl ctl
);
    import rv_pkg::*;

    logic wb_live;
    logic hit_a;
    logic hit_b;

    // ---------------------------------------------------------------------
    // forwarding, writeback to execute only
    // ---------------------------------------------------------------------
    assign wb_live = ctl.wb_wen && (ctl.wb_rd != '0);
    assign hit_a   = wb_live && (ctl.wb_rd == ctl.ex_rs1);
    assign hit_b   = wb_live && (ctl.wb_rd == ctl.ex_rs2);

    assign ctl.fwd_a = hit_a ? FWD_WB : FWD_RF;
    assign ctl.fwd_b = hit_b ? FWD_WB : FWD_RF;

    // ---------------------------------------------------------------------
    // redirect from execute
    // ---------------------------------------------------------------------
    // the two younger slots are wrong path, fetch restarts at the target
    assign ctl.flush_d  = ctl.redirect;
    assign ctl.flush_e  = ctl.redirect;
    assign ctl.fetch_pc = ctl.redirect_pc;

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic            ex_valid,
    input  rv_pkg::ex_pkt_t ex_data,
    input  rv_pkg::wb_pkt_t wb_data,
    pipe_ctrl_if.stage      ctl,
    output logic            wb_out_valid,
    output rv_pkg::wb_pkt_t wb_out
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] link_pc;
    logic            taken;

    assign ctl.ex_rs1 = ex_data.rs1;
    assign ctl.ex_rs2 = ex_data.rs2;

    // forwarding from writeback
    assign op_a  = (ctl.fwd_a == FWD_WB) ? wb_data.result : ex_data.rs1_val;
    assign op_b  = (ctl.fwd_b == FWD_WB) ? wb_data.result : ex_data.rs2_val;
    assign alu_b = ex_data.use_imm ? ex_data.imm : op_b;

    always_comb begin
        case (ex_data.alu_op)
            ALU_ADD:    alu_res = op_a + alu_b;
            ALU_SUB:    alu_res = op_a - alu_b;
            ALU_AND:    alu_res = op_a & alu_b;
            ALU_OR:     alu_res = op_a | alu_b;
            ALU_XOR:    alu_res = op_a ^ alu_b;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(alu_b));
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex_data.br_kind)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign ctl.redirect    = ex_valid && taken;
    assign ctl.redirect_pc = ex_data.pc + ex_data.imm;       // branch and jal target

    assign link_pc = ex_data.pc + XLEN'(4);

    assign wb_out_valid   = ex_valid;
    assign wb_out.pc      = ex_data.pc;
    assign wb_out.rd      = ex_data.rd;
    assign wb_out.reg_wen = ex_data.reg_wen;
    assign wb_out.result  = (ex_data.br_kind == BR_JAL) ? link_pc : alu_res;

endmodule

/* source/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            id_valid,
    input  rv_pkg::if_pkt_t id_data,
    input  logic            wb_valid,
    input  rv_pkg::wb_pkt_t wb_data,
    output logic            ex_valid,
    output rv_pkg::ex_pkt_t ex_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]       rf_q [NUM_REGS];
    logic [XLEN-1:0]       instr;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       u_imm;
    logic [XLEN-1:0]       b_imm;
    logic [XLEN-1:0]       j_imm;
    alu_op_e               f3_op;
    logic                  f3_ok;                            // funct3 is in the subset
    logic                  wb_write;

    assign instr  = id_data.instr;
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign wb_write = wb_valid && wb_data.reg_wen && (wb_data.rd != '0);

    // ---------------------------------------------------------------------
    // register file, written from writeback
    // ---------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_write) begin
            rf_q[wb_data.rd] <= wb_data.result;
        end
    end

    // write-through so a same-cycle writeback is seen
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_write && (wb_data.rd == idx)) begin
            val = wb_data.result;
        end else begin
            val = rf_q[idx];
        end
        return val;
    endfunction

    // op and op-imm share the funct3 table
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;                                // commits without a write
            end
        endcase
    end

    always_comb begin
        ex_data         = '0;
        ex_data.pc      = id_data.pc;
        ex_data.rs1     = rs1;
        ex_data.rs2     = rs2;
        ex_data.rd      = rd;
        ex_data.rs1_val = read_port(rs1);
        ex_data.rs2_val = read_port(rs2);
        ex_data.alu_op  = ALU_ADD;
        ex_data.br_kind = BR_NONE;
        case (instr[6:0])
            OPC_OP: begin
                ex_data.alu_op  = (funct3 == 3'b000 && instr[30]) ? ALU_SUB : f3_op;
                ex_data.reg_wen = f3_ok;
            end
            OPC_OP_IMM: begin
                ex_data.alu_op  = f3_op;
                ex_data.use_imm = 1'b1;
                ex_data.imm     = i_imm;
                ex_data.reg_wen = f3_ok;
            end
            OPC_LUI: begin
                ex_data.alu_op  = ALU_PASS_B;
                ex_data.use_imm = 1'b1;
                ex_data.imm     = u_imm;
                ex_data.reg_wen = 1'b1;
            end
            OPC_JAL: begin
                ex_data.imm     = j_imm;
                ex_data.br_kind = BR_JAL;
                ex_data.reg_wen = 1'b1;                      // link
            end
            OPC_BRANCH: begin
                ex_data.imm = b_imm;
                if (funct3 == 3'b000) begin
                    ex_data.br_kind = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    ex_data.br_kind = BR_NE;
                end
            end
            default: ;
        endcase
        ex_data.reg_wen = ex_data.reg_wen && (rd != '0);     // x0 stays zero
    end

    assign ex_valid = id_valid;

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = rv_pkg::RESET_PC
) (
    input  logic                    clock,
    input  logic                    rst_n,
    output logic                    instr_req,
    output logic [rv_pkg::XLEN-1:0] instr_addr,
    input  logic [rv_pkg::XLEN-1:0] instr_rdata,
    input  logic                    instr_ack,
    pipe_ctrl_if.stage              ctl,
    output logic                    if_valid,
    output rv_pkg::if_pkt_t         if_data
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT_LOW
    } fetch_state_e;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;                                   // address of the open request
    logic [XLEN-1:0] target_q;
    logic            discard_q;                              // open fetch is wrong path
    logic            done;

    assign done = (state_q == F_REQ) && instr_ack;

    // ---------------------------------------------------------------------
    // four-phase handshake and pc
    // ---------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= F_IDLE;
            pc_q      <= RESET_PC;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                F_IDLE:     state_q <= F_REQ;
                F_REQ:      if (instr_ack) state_q <= F_WAIT_LOW;
                F_WAIT_LOW: if (!instr_ack) state_q <= F_REQ;
                default:    state_q <= F_IDLE;
            endcase

            if (done) begin
                discard_q <= 1'b0;
                if (ctl.flush_d) begin
                    pc_q <= ctl.fetch_pc;                    // word killed by decode flush
                end else if (discard_q) begin
                    pc_q <= target_q;
                end else begin
                    pc_q <= pc_q + XLEN'(4);
                end
            end else if (ctl.flush_d) begin
                if (state_q == F_REQ) begin
                    discard_q <= 1'b1;                       // address must stay stable
                end else begin
                    pc_q <= ctl.fetch_pc;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctl.flush_d && (state_q == F_REQ) && !instr_ack) begin
            target_q <= ctl.fetch_pc;
        end
    end

    assign instr_req  = (state_q == F_REQ);
    assign instr_addr = pc_q;

    assign if_valid      = done && !discard_q;
    assign if_data.pc    = pc_q;
    assign if_data.instr = instr_rdata;

endmodule

/* source/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = rv_pkg::if_pkt_t
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     load,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= load && in_valid && !flush;         // no load means bubble
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= in_data;                             // held otherwise
        end
    end

endmodule

/* source/pipe_ctrl_if.sv */
`timescale 1ns/1ps

interface pipe_ctrl_if;
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0] ex_rs1;                           // sources of the op in execute
    logic [REG_ADDR_W-1:0] ex_rs2;
    logic                  redirect;                         // taken branch or jump
    logic [XLEN-1:0]       redirect_pc;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_wen;                           // valid and writing
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic                  flush_d;
    logic                  flush_e;
    logic [XLEN-1:0]       fetch_pc;                         // new fetch address on flush

    modport ctrl (
        input  ex_rs1, ex_rs2, redirect, redirect_pc, wb_rd, wb_wen,
        output fwd_a, fwd_b, flush_d, flush_e, fetch_pc
    );

    modport stage (
        output ex_rs1, ex_rs2, redirect, redirect_pc, wb_rd, wb_wen,
        input  fwd_a, fwd_b, flush_d, flush_e, fetch_pc
    );

endinterface

/* source/rv_pkg.sv */
package rv_pkg;

    // ---------------------------------------------------------------------
    // widths and reset vector
    // ---------------------------------------------------------------------
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;
    parameter int NUM_REGS   = 32;

    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000;   // first fetch address

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                                           // lui
    } alu_op_e;

    typedef enum logic {
        FWD_RF,                                              // value read in decode
        FWD_WB                                               // result in writeback
    } fwd_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    // ---------------------------------------------------------------------
    // stage payloads
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  reg_wen;                      // never set for rd x0
        br_kind_e              br_kind;
    } ex_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic [XLEN-1:0]       result;
    } wb_pkt_t;

endpackage
